// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_control.sv
  - dcache_datapath.sv
  - victim_buffer.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

// File: dcache_control.sv
`default_nettype none

module dcache_control
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       hit,
    input  logic       way_hit,
    input  logic       lru_way,
    input  logic       lru_valid,
    input  logic       lru_dirty,
    input  logic       victim_hit,
    input  logic       victim_way_hit,
    input  logic       victim_lru_way,
    input  logic       victim_lru_dirty_valid,
    input  logic       victim_hit_dirty,
    input  logic       pmem_resp,
    output logic       mem_resp,
    output logic       pmem_read,
    output logic       pmem_write,
    output logic       pmem_addr_sel,
    output logic [1:0] data_sel,
    output logic       load_tag,
    output logic       load_valid,
    output logic       load_dirty,
    output logic       dirty_value,
    output logic       load_lru,
    output logic       lru_value,
    output logic       victim_load,
    output logic       victim_load_way,
    output logic       victim_dirty_value,
    output logic       victim_load_lru
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        resp_q;                                              // Answered in the last cycle
    logic        swap_dirty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= idle;
            resp_q <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            resp_q <= mem_resp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == cache_to_victim)
            swap_dirty <= victim_hit_dirty;                           // Victim dirty bit heads back
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            idle:
            begin
                if (mem_read || mem_write)
                    next_state = check;
            end
            check:
            begin
                if (!(mem_read || mem_write))
                    next_state = idle;
                else if (resp_q || hit)
                    next_state = check;                               // Wait out the old request
                else if (victim_hit)
                    next_state = cache_to_victim;
                else
                    next_state = buffer;
            end
            cache_to_victim:
                next_state = victim_to_cache;
            victim_to_cache:
                next_state = check;
            buffer:
            begin
                if (!lru_valid)
                    next_state = read_from_mem;                       // Empty way, nothing to move
                else if (victim_lru_dirty_valid)
                    next_state = write_to_mem;
                else
                    next_state = write_to_victim;
            end
            write_to_mem:
            begin
                if (pmem_resp)
                    next_state = write_to_victim;
            end
            write_to_victim:
                next_state = read_from_mem;
            read_from_mem:
            begin
                if (pmem_resp)
                    next_state = check;
            end
            default:
                next_state = idle;
        endcase
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    always_comb
    begin
        mem_resp           = 1'b0;
        pmem_read          = 1'b0;
        pmem_write         = 1'b0;
        pmem_addr_sel      = addr_sel_cpu;
        data_sel           = data_sel_none;
        load_tag           = 1'b0;
        load_valid         = 1'b0;
        load_dirty         = 1'b0;
        dirty_value        = 1'b0;
        load_lru           = 1'b0;
        lru_value          = 1'b0;
        victim_load        = 1'b0;
        victim_load_way    = victim_lru_way;
        victim_dirty_value = lru_valid & lru_dirty;                   // Stale dirty of an empty way dropped
        victim_load_lru    = 1'b0;
        case (state)
            check:
            begin
                if (hit && !resp_q)
                begin
                    mem_resp  = 1'b1;
                    load_lru  = 1'b1;
                    lru_value = ~way_hit;
                    if (mem_write)
                    begin
                        data_sel    = data_sel_cpu;
                        load_dirty  = 1'b1;
                        dirty_value = 1'b1;
                    end
                end
            end
            cache_to_victim:
            begin
                victim_load     = 1'b1;
                victim_load_way = victim_way_hit;                     // Evicted line takes the freed entry
                victim_load_lru = 1'b1;
            end
            victim_to_cache:
            begin
                data_sel    = data_sel_victim;
                load_tag    = 1'b1;
                load_valid  = 1'b1;
                load_dirty  = 1'b1;
                dirty_value = swap_dirty;
                load_lru    = 1'b1;
                lru_value   = ~lru_way;
            end
            write_to_mem:
            begin
                pmem_write    = 1'b1;
                pmem_addr_sel = addr_sel_victim;
            end
            write_to_victim:
            begin
                victim_load     = 1'b1;
                victim_load_lru = 1'b1;
            end
            read_from_mem:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    data_sel   = data_sel_mem;
                    load_tag   = 1'b1;
                    load_valid = 1'b1;
                    load_dirty = 1'b1;
                    load_lru   = 1'b1;
                    lru_value  = ~lru_way;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_datapath.sv
`default_nettype none

module dcache_datapath
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [addr_width-1:0]      mem_addr,
    input  logic [word_width-1:0]      mem_wdata,
    input  logic [line_width-1:0]      line_from_victim,
    input  logic [line_width-1:0]      pmem_rdata,
    input  logic [1:0]                 data_sel,
    input  logic                       load_tag,
    input  logic                       load_valid,
    input  logic                       load_dirty,
    input  logic                       dirty_value,
    input  logic                       load_lru,
    input  logic                       lru_value,
    output logic                       hit,
    output logic                       way_hit,
    output logic                       lru_way,
    output logic                       lru_valid,
    output logic                       lru_dirty,
    output logic [word_width-1:0]      mem_rdata,
    output logic [line_width-1:0]      lru_line,
    output logic [line_addr_width-1:0] lru_line_addr
);

    cache_addr_t                       addr;
    logic [tag_width-1:0]              tag_array   [2][set_count];
    logic                              valid_array [2][set_count];
    logic                              dirty_array [2][set_count];
    logic [line_width-1:0]             data_array  [2][set_count];
    logic                              lru_array   [set_count];
    logic [1:0]                        way_match;
    logic [line_width-1:0]             hit_line;
    logic [line_width-1:0]             merged_line;
    logic [line_width-1:0]             swap_line;
    logic [line_width-1:0]             write_line;
    logic                              target_way;
    logic [$clog2(words_per_line)-1:0] word_sel;

    assign addr     = mem_addr;
    assign word_sel = addr.main.offset[offset_width-1:2];

    //////////////////////////////
    // Lookup
    //////////////////////////////

    always_comb
    begin
        for (int w = 0; w < 2; w++)
        begin
            way_match[w] = valid_array[w][addr.main.set] &&
                           (tag_array[w][addr.main.set] == addr.main.tag);
        end
    end

    assign hit       = |way_match;
    assign way_hit   = way_match[1];
    assign hit_line  = data_array[way_hit][addr.main.set];
    assign mem_rdata = hit_line[word_sel*word_width +: word_width];

    assign lru_way       = lru_array[addr.main.set];
    assign lru_valid     = valid_array[lru_way][addr.main.set];
    assign lru_dirty     = dirty_array[lru_way][addr.main.set];
    assign lru_line      = data_array[lru_way][addr.main.set];
    assign lru_line_addr = {tag_array[lru_way][addr.main.set], addr.main.set};

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_comb
    begin
        merged_line = hit_line;
        merged_line[word_sel*word_width +: word_width] = mem_wdata;
    end

    always_comb
    begin
        case (data_sel)
            data_sel_mem:
                write_line = pmem_rdata;
            data_sel_victim:
                write_line = swap_line;
            default:
                write_line = merged_line;
        endcase
    end

    // CPU writes go to the hit way, fills and swaps to the LRU way
    assign target_way = (data_sel == data_sel_cpu) ? way_hit : lru_way;

    always_ff @(posedge clk)
    begin
        swap_line <= line_from_victim;                                // Holds the victim line one cycle
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < set_count; s++)
            begin
                valid_array[0][s] <= 1'b0;
                valid_array[1][s] <= 1'b0;
                lru_array[s]      <= 1'b0;
            end
        end
        else
        begin
            if (load_valid)
                valid_array[target_way][addr.main.set] <= 1'b1;
            if (load_lru)
                lru_array[addr.main.set] <= lru_value;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_tag)
            tag_array[target_way][addr.main.set] <= addr.main.tag;
        if (load_dirty)
            dirty_array[target_way][addr.main.set] <= dirty_value;
        if (data_sel != data_sel_none)
            data_array[target_way][addr.main.set] <= write_line;
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    localparam int addr_width      = 32;
    localparam int word_width      = 32;
    localparam int words_per_line  = 4;
    localparam int line_width      = word_width * words_per_line;
    localparam int offset_width    = 4;                                // Two byte bits, two word bits
    localparam int set_count       = 8;
    localparam int set_width       = 3;
    localparam int tag_width       = addr_width - set_width - offset_width;
    localparam int line_addr_width = addr_width - offset_width;        // Tag and set together

    // Source of the line written into a main cache way
    localparam logic [1:0] data_sel_none   = 2'd0;
    localparam logic [1:0] data_sel_cpu    = 2'd1;
    localparam logic [1:0] data_sel_mem    = 2'd2;
    localparam logic [1:0] data_sel_victim = 2'd3;

    localparam logic addr_sel_cpu    = 1'b0;                          // Refill from the CPU line
    localparam logic addr_sel_victim = 1'b1;                          // Write back the victim line

    //////////////////////////////
    // Address views
    //////////////////////////////

    typedef union packed {
        struct packed {
            logic [tag_width-1:0]    tag;
            logic [set_width-1:0]    set;
            logic [offset_width-1:0] offset;
        } main;                                                       // Main cache lookup
        struct packed {
            logic [line_addr_width-1:0] line_addr;
            logic [offset_width-1:0]    offset;
        } line;                                                       // Victim buffer and memory
    } cache_addr_t;

    typedef enum logic [3:0] {
        idle, check, cache_to_victim, victim_to_cache,
        buffer, write_to_mem, write_to_victim, read_from_mem
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: dcache_tests.txt
// Columns are op code (0 read, 1 write), byte address, write data and check code
// Check code 0 skips, 1 compares data, 2 also wants a one-cycle hit, 3 a victim swap
// Reads only, cold misses and hits
0 00001000 00000000 1
0 00001000 00000000 2
0 00001014 00000000 1
0 00001018 00000000 2
// Three lines of set 2, then two lines come back from the victim buffer
0 00002020 00000000 1
0 000020a4 00000000 1
0 00002128 00000000 1
0 0000202c 00000000 3
0 000020a0 00000000 3
// Write hit, then the written word and its neighbor
1 00001004 a5a50001 0
0 00001004 00000000 2
0 00001008 00000000 2
// Dirty lines of set 3 pass through the victim buffer out to memory
1 00003030 11113030 0
1 000030b4 222230b4 0
1 00003138 33333138 0
1 000031bc 444431bc 0
0 00003230 00000000 1
0 000032b0 00000000 1
0 00003330 00000000 1
0 000033b0 00000000 1
// Written words come back from memory
0 00003030 00000000 1
0 0000303c 00000000 2
0 000030b4 00000000 1
0 00003138 00000000 1
0 000031bc 00000000 1

// File: dcache_top.sv
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [word_width-1:0] mem_wdata,
    output logic [word_width-1:0] mem_rdata,
    output logic                  mem_resp,
    output logic                  pmem_read,
    output logic                  pmem_write,
    output logic [addr_width-1:0] pmem_addr,
    output logic [line_width-1:0] pmem_wdata,
    input  logic [line_width-1:0] pmem_rdata,
    input  logic                  pmem_resp
);

    cache_addr_t                cpu_addr;
    logic                       hit;
    logic                       way_hit;
    logic                       lru_way;
    logic                       lru_valid;
    logic                       lru_dirty;
    logic                       victim_hit;
    logic                       victim_way_hit;
    logic                       victim_lru_way;
    logic                       victim_lru_dirty_valid;
    logic                       victim_hit_dirty;
    logic                       pmem_addr_sel;
    logic [1:0]                 data_sel;
    logic                       load_tag;
    logic                       load_valid;
    logic                       load_dirty;
    logic                       dirty_value;
    logic                       load_lru;
    logic                       lru_value;
    logic                       victim_load;
    logic                       victim_load_way;
    logic                       victim_dirty_value;
    logic                       victim_load_lru;
    logic [line_width-1:0]      line_from_victim;
    logic [line_width-1:0]      lru_line;
    logic [line_addr_width-1:0] lru_line_addr;
    logic [line_addr_width-1:0] writeback_addr;

    assign cpu_addr = mem_addr;

    // Memory always sees whole lines
    assign pmem_addr = (pmem_addr_sel == addr_sel_victim) ?
                       {writeback_addr, {offset_width{1'b0}}} :
                       {cpu_addr.line.line_addr, {offset_width{1'b0}}};

    dcache_control control0 (.*);

    dcache_datapath datapath0 (.*);

    victim_buffer victim0 (
        .writeback_line (pmem_wdata),
        .*
    );

endmodule

`default_nettype wire

// File: flist.f
dcache_pkg.sv
dcache_control.sv
dcache_datapath.sv
victim_buffer.sv
dcache_top.sv
tb_dcache.sv

// File: tb_dcache.sv
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int timeout_cycles  = 200;
    localparam int mem_words_count = 4096;                            // 16 KiB of modeled memory
    localparam int max_ops         = 64;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  mem_read;
    logic                  mem_write;
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [word_width-1:0] mem_rdata;
    logic                  mem_resp;
    logic                  pmem_read;
    logic                  pmem_write;
    logic [addr_width-1:0] pmem_addr;
    logic [line_width-1:0] pmem_wdata;
    logic [line_width-1:0] pmem_rdata;
    logic                  pmem_resp;

    logic [word_width-1:0] mem_words [mem_words_count];
    logic [word_width-1:0] ref_words [mem_words_count];
    logic [31:0]           test_table [4*max_ops];                    // Four columns per operation
    integer                seed = 32'h5cc6_6ac3;
    int                    wait_left;
    int                    line_base;
    int                    read_cycles;
    int                    write_cycles;
    int                    error_count;
    int                    check_count;

    dcache_top dut0 (.*);

    always #10 clk = ~clk;

    function automatic int word_index(input logic [addr_width-1:0] byte_addr);
        return byte_addr[13:2];
    endfunction

    function automatic logic [word_width-1:0] fill_value(input logic [addr_width-1:0] byte_addr);
        return ~byte_addr;
    endfunction

    //////////////////////////////
    // Memory model
    //////////////////////////////

    always @(negedge clk)
    begin
        if (pmem_read)
            read_cycles++;
        if (pmem_write)
            write_cycles++;
    end

    always
    begin
        @(posedge clk);
        #2;
        pmem_resp = 1'b0;
        if (!rst && (pmem_read || pmem_write))
        begin
            if (wait_left == 0)
                wait_left = 1 + ({$random(seed)} % 6);                // Between 1 and 6 cycles
            wait_left--;
            if (wait_left == 0)
            begin
                line_base = word_index(pmem_addr);
                for (int i = 0; i < words_per_line; i++)
                begin
                    if (pmem_write)
                        mem_words[line_base + i] = pmem_wdata[i*word_width +: word_width];
                    else
                        pmem_rdata[i*word_width +: word_width] = mem_words[line_base + i];
                end
                pmem_resp = 1'b1;
            end
        end
    end

    //////////////////////////////
    // CPU side
    //////////////////////////////

    // Called a little after a rising edge, returns at the same point
    task automatic cpu_access(input bit is_write, input logic [addr_width-1:0] addr,
                              input logic [word_width-1:0] wdata,
                              output logic [word_width-1:0] rdata, output int cycles);
        int waited;
        mem_read  = !is_write;
        mem_write = is_write;
        mem_addr  = addr;
        mem_wdata = wdata;
        waited    = 0;
        rdata     = '0;
        cycles    = 0;
        @(negedge clk);
        while (!mem_resp && waited < timeout_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!mem_resp)
        begin
            $display("Stall: no mem_resp within %0d cycles for address %h", timeout_cycles, addr);
            $display("TEST FAIL");
            $finish;
        end
        else
        begin
            rdata  = mem_rdata;
            cycles = waited;                                          // Rising edges before the answer
            @(posedge clk);
            #2;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    endtask

    task automatic run_table();
        logic [31:0]           op;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        logic [31:0]           check_code;
        logic [word_width-1:0] got;
        logic [word_width-1:0] expected;
        int                    cycles;
        int                    reads_before;
        bit                    seen_write;
        seen_write = 1'b0;
        for (int n = 0; n < max_ops && test_table[4*n] !== 32'hffff_ffff; n++)
        begin
            op         = test_table[4*n];
            addr       = test_table[4*n + 1];
            wdata      = test_table[4*n + 2];
            check_code = test_table[4*n + 3];
            if (addr >= mem_words_count * 4)
            begin
                error_count++;
                $display("Test line %0d uses address %h outside the modeled memory", n, addr);
                continue;
            end
            if (op == 1 && !seen_write)
            begin
                seen_write = 1'b1;                                    // End of the read-only section
                check_count++;
                if (write_cycles != 0)
                begin
                    error_count++;
                    $display("** Error at %0t: %0d pmem_write cycles during reads only",
                             $time, write_cycles);
                end
            end
            reads_before = read_cycles;
            expected     = ref_words[word_index(addr)];
            cpu_access(op == 1, addr, wdata, got, cycles);
            if (op == 1)
                ref_words[word_index(addr)] = wdata;
            else if (check_code != 0)
            begin
                check_count++;
                if (got !== expected)
                begin
                    error_count++;
                    $display("** Error at %0t: read %h returned %h, expected %h",
                             $time, addr, got, expected);
                end
                if (check_code == 2 && cycles != 1)
                begin
                    error_count++;
                    $display("** Error at %0t: hit on %h answered after %0d cycles, expected 1",
                             $time, addr, cycles);
                end
                if (check_code == 3 && (cycles != 4 || read_cycles != reads_before))
                begin
                    error_count++;
                    $display("** Error at %0t: swap for %h took %0d cycles and %0d pmem_read cycles",
                             $time, addr, cycles, read_cycles - reads_before);
                end
            end
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        pmem_rdata = '0;
        pmem_resp  = 1'b0;
        wait_left    = 0;
        read_cycles  = 0;
        write_cycles = 0;
        error_count  = 0;
        check_count  = 0;
        for (int i = 0; i < mem_words_count; i++)
        begin
            mem_words[i] = fill_value(i * 4);
            ref_words[i] = fill_value(i * 4);
        end
        for (int i = 0; i < 4 * max_ops; i++)
            test_table[i] = 32'hffff_ffff;                            // Marks the end of the table
        $readmemh("dcache_tests.txt", test_table);
        if (test_table[0] === 32'hffff_ffff)
        begin
            error_count++;
            $display("No operations were read from dcache_tests.txt");
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        run_table();
        if (write_cycles == 0)
        begin
            error_count++;
            $display("No dirty line was ever written back to memory");
        end
        $display("Done with %0d checks and %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: victim_buffer.sv
`default_nettype none

module victim_buffer
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [addr_width-1:0]      mem_addr,
    input  logic [line_width-1:0]      lru_line,
    input  logic [line_addr_width-1:0] lru_line_addr,
    input  logic                       lru_valid,
    input  logic                       lru_dirty,
    input  logic                       victim_load,
    input  logic                       victim_load_way,
    input  logic                       victim_dirty_value,
    input  logic                       victim_load_lru,
    output logic                       victim_hit,
    output logic                       victim_way_hit,
    output logic                       victim_hit_dirty,
    output logic                       victim_lru_way,
    output logic                       victim_lru_dirty_valid,
    output logic [line_width-1:0]      line_from_victim,
    output logic [line_width-1:0]      writeback_line,
    output logic [line_addr_width-1:0] writeback_addr
);

    cache_addr_t                addr;
    logic                       valid_q [2];
    logic                       dirty_q [2];
    logic [line_addr_width-1:0] addr_q  [2];
    logic [line_width-1:0]      line_q  [2];
    logic                       lru_q;
    logic [1:0]                 entry_match;

    assign addr = mem_addr;

    always_comb
    begin
        for (int e = 0; e < 2; e++)
        begin
            entry_match[e] = valid_q[e] && (addr_q[e] == addr.line.line_addr);
        end
    end

    assign victim_hit       = |entry_match;
    assign victim_way_hit   = entry_match[1];
    assign victim_hit_dirty = dirty_q[victim_way_hit];
    assign line_from_victim = line_q[victim_way_hit];

    // LRU entry is the next to leave, and the one written back
    assign victim_lru_way         = lru_q;
    assign victim_lru_dirty_valid = valid_q[lru_q] && dirty_q[lru_q];
    assign writeback_line         = line_q[lru_q];
    assign writeback_addr         = addr_q[lru_q];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q[0] <= 1'b0;
            valid_q[1] <= 1'b0;
            lru_q      <= 1'b0;
        end
        else
        begin
            if (victim_load)
                valid_q[victim_load_way] <= lru_valid;
            if (victim_load_lru)
                lru_q <= ~victim_load_way;                            // Newest entry is most recent
        end
    end

    always_ff @(posedge clk)
    begin
        if (victim_load)
        begin
            addr_q[victim_load_way]  <= lru_line_addr;
            line_q[victim_load_way]  <= lru_line;
            dirty_q[victim_load_way] <= victim_dirty_value & lru_dirty;
        end
    end

endmodule

`default_nettype wire
